// ==== design/bridge_ctrl_pkg.sv ====
`default_nettype none

package bridge_ctrl_pkg;

  typedef logic [2:0]  cmd_code_t;  // Bus command code
  typedef logic [3:0]  leg_t;       // One bit per bridge leg
  typedef logic [15:0] duty_t;      // PWM duty and counter

  localparam cmd_code_t CMD_PAUSE     = 3'd0;
  localparam cmd_code_t CMD_PLUS      = 3'd1;
  localparam cmd_code_t CMD_MINUS     = 3'd2;
  localparam cmd_code_t CMD_BALLAST_P = 3'd3;
  localparam cmd_code_t CMD_BALLAST_N = 3'd4;
  localparam cmd_code_t CMD_START     = 3'd5;
  localparam cmd_code_t CMD_SHUTDOWN  = 3'd6;
  localparam cmd_code_t CMD_DISCHARGE = 3'd7;

  localparam int RAMP_STEPS = 15;

  // Roughly doubling duty per step, last one fully on
  localparam duty_t RAMP_DUTY [RAMP_STEPS] = '{
    16'd5,    16'd11,   16'd23,    16'd46,    16'd90,
    16'd174,  16'd338,  16'd654,   16'd1264,  16'd2441,
    16'd4715, 16'd9105, 16'd17580, 16'd33943, 16'd65535
  };

  typedef struct packed {
    leg_t top;
    leg_t bot;
    logic plus;
    logic minus;
    logic pause_p;
    logic pause_n;
  } bridge_cmd_t;

  // Order is top, bot, plus, minus, pause_p, pause_n
  localparam bridge_cmd_t BRIDGE_PLUS      = '{4'b0001, 4'b0010, 1'b1, 1'b0, 1'b0, 1'b0};
  localparam bridge_cmd_t BRIDGE_MINUS     = '{4'b0010, 4'b0001, 1'b0, 1'b1, 1'b0, 1'b0};
  localparam bridge_cmd_t BRIDGE_BALLAST_P = '{4'b0100, 4'b1000, 1'b0, 1'b0, 1'b1, 1'b0};
  localparam bridge_cmd_t BRIDGE_BALLAST_N = '{4'b1000, 4'b0100, 1'b0, 1'b0, 1'b0, 1'b1};
  localparam bridge_cmd_t BRIDGE_OFF       = '{4'b0000, 4'b0000, 1'b0, 1'b0, 1'b0, 1'b0};

  typedef struct packed {
    leg_t err_dr;  // Driver fault per leg
    logic err_u;   // Overvoltage
    logic err_i;   // Overcurrent
    logic bt;      // Overtemperature
    logic stop_k;  // Emergency stop
  } fault_t;

  typedef enum logic [2:0] {
    IDLE,
    START_ARM,
    DISCH_0,
    DISCH_1,
    DISCH_2,
    FAULT
  } dec_state_t;

endpackage

`default_nettype wire

// ==== design/bridge_ctrl_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridge_ctrl_top
  import bridge_ctrl_pkg::*;
#(
  parameter int FILTER_WIDTH = 8,
  parameter int WAITSTATES   = 4,
  parameter int STEP_CYCLES  = 49999999  // One second at 50 MHz
) (
  input  wire       clk,
  input  wire       rstn,
  input  wire       i_strobe,
  input  wire  cmd_code_t i_cmd,
  input  wire  leg_t i_err_dr_n,
  input  wire       i_err_u_n,
  input  wire       i_err_i_n,
  input  wire       i_bt_n,
  input  wire       i_stop_k_n,
  output leg_t      o_top,
  output leg_t      o_bot,
  output logic      o_plus,
  output logic      o_minus,
  output logic      o_pause_p,
  output logic      o_pause_n,
  output logic      o_fan,
  output logic      o_start,
  output logic      o_charge,
  output logic      o_ch,
  output logic      o_break,
  output logic      o_stop,
  output logic      o_avv,
  output logic      o_avi,
  output logic      o_td,
  output leg_t      o_erbd
);

  localparam int LANES = 1 + $bits(cmd_code_t) + $bits(fault_t);

  fault_t           faults_raw;
  fault_t           faults;
  cmd_code_t        cmd;
  logic             strobe;
  logic [LANES-1:0] clean;
  bridge_cmd_t      bridge_cmd;
  bridge_cmd_t      bridge;
  logic             bridge_load;
  logic             bridge_off;
  logic             busy;
  logic             start_req;
  logic             abort;
  logic             ramping;
  logic             ramp_done;
  logic             fault;

  // Fault pins are active low
  assign faults_raw = {~i_err_dr_n, ~i_err_u_n, ~i_err_i_n, ~i_bt_n, ~i_stop_k_n};

  input_filter #(.WIDTH(FILTER_WIDTH), .LANES(LANES)) filter_i (
    .clk(clk), .rstn(rstn), .i_raw({i_strobe, i_cmd, faults_raw}), .o_clean(clean)
  );

  assign {strobe, cmd, faults} = clean;

  cmd_decoder decoder_i (
    .clk(clk), .rstn(rstn), .i_strobe(strobe), .i_cmd(cmd), .i_busy(busy),
    .i_ramping(ramping), .i_ramp_done(ramp_done), .i_fault(fault),
    .o_bridge_cmd(bridge_cmd), .o_bridge_load(bridge_load), .o_bridge_off(bridge_off),
    .o_start_req(start_req), .o_abort(abort), .o_fan(o_fan)
  );

  bridge_driver #(.WAITSTATES(WAITSTATES)) driver_i (
    .clk(clk), .rstn(rstn), .i_cmd(bridge_cmd), .i_load(bridge_load), .i_off(bridge_off),
    .i_fault(fault), .o_bridge(bridge), .o_busy(busy)
  );

  soft_start #(.STEP_CYCLES(STEP_CYCLES)) soft_start_i (
    .clk(clk), .rstn(rstn), .i_start_req(start_req), .i_abort(abort), .i_fault(fault),
    .o_ramping(ramping), .o_ramp_done(ramp_done), .o_start(o_start),
    .o_charge(o_charge), .o_ch(o_ch)
  );

  fault_monitor fault_i (
    .clk(clk), .rstn(rstn), .i_faults(faults), .o_fault(fault), .o_stop(o_stop),
    .o_avv(o_avv), .o_avi(o_avi), .o_td(o_td), .o_erbd(o_erbd)
  );

  assign o_top     = bridge.top;
  assign o_bot     = bridge.bot;
  assign o_plus    = bridge.plus;
  assign o_minus   = bridge.minus;
  assign o_pause_p = bridge.pause_p;
  assign o_pause_n = bridge.pause_n;
  assign o_break   = fault;

endmodule

`default_nettype wire

// ==== design/bridge_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridge_driver
  import bridge_ctrl_pkg::*;
#(
  parameter int WAITSTATES = 4
) (
  input  wire         clk,
  input  wire         rstn,
  input  wire  bridge_cmd_t i_cmd,
  input  wire         i_load,
  input  wire         i_off,
  input  wire         i_fault,
  output bridge_cmd_t o_bridge,
  output logic        o_busy
);

  localparam int CNT_W = (WAITSTATES > 1) ? $clog2(WAITSTATES) : 1;

  typedef logic [CNT_W-1:0] dead_cnt_t;

  bridge_cmd_t next_q;  // Pattern waiting for dead time
  dead_cnt_t   cnt_q;
  logic        pend_q;

  always_ff @(posedge clk) begin
    if (i_load) begin
      next_q <= i_cmd;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_bridge <= BRIDGE_OFF;
      pend_q   <= 1'b0;
      cnt_q    <= '0;
    end else if (i_fault) begin
      o_bridge <= BRIDGE_OFF;
      pend_q   <= 1'b0;  // Pending load dropped
    end else if (i_load) begin
      o_bridge <= BRIDGE_OFF;  // Legs off first
      pend_q   <= 1'b1;
      cnt_q    <= dead_cnt_t'(WAITSTATES - 1);
    end else begin
      if (pend_q) begin
        if (cnt_q == '0) begin
          o_bridge <= next_q;  // Dead time over
          pend_q   <= 1'b0;
        end else begin
          cnt_q <= cnt_q - dead_cnt_t'(1);
        end
      end
      if (i_off) begin
        o_bridge <= BRIDGE_OFF;
      end
    end
  end

  assign o_busy = pend_q;

endmodule

`default_nettype wire

// ==== design/cmd_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module cmd_decoder
  import bridge_ctrl_pkg::*;
(
  input  wire         clk,
  input  wire         rstn,
  input  wire         i_strobe,
  input  wire  cmd_code_t i_cmd,
  input  wire         i_busy,
  input  wire         i_ramping,
  input  wire         i_ramp_done,
  input  wire         i_fault,
  output bridge_cmd_t o_bridge_cmd,
  output logic        o_bridge_load,
  output logic        o_bridge_off,
  output logic        o_start_req,
  output logic        o_abort,
  output logic        o_fan
);

  dec_state_t state_q;
  logic       strobe_q;
  logic       ready_q;      // Device ready for bridge commands
  logic       strobe_fall;
  logic       accept_leg;

  assign strobe_fall = strobe_q & ~i_strobe;
  assign accept_leg  = ready_q & ~i_ramping;

  function automatic bridge_cmd_t pattern_of(input cmd_code_t code);
    case (code)
      CMD_PLUS:      return BRIDGE_PLUS;
      CMD_MINUS:     return BRIDGE_MINUS;
      CMD_BALLAST_P: return BRIDGE_BALLAST_P;
      CMD_BALLAST_N: return BRIDGE_BALLAST_N;
      default:       return BRIDGE_OFF;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (strobe_fall) begin
      o_bridge_cmd <= pattern_of(i_cmd);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q       <= IDLE;
      strobe_q      <= 1'b0;
      ready_q       <= 1'b0;
      o_fan         <= 1'b0;
      o_bridge_load <= 1'b0;
      o_bridge_off  <= 1'b0;
      o_start_req   <= 1'b0;
      o_abort       <= 1'b0;
    end else begin
      strobe_q      <= i_strobe;
      o_bridge_load <= 1'b0;
      o_bridge_off  <= 1'b0;
      o_start_req   <= 1'b0;
      o_abort       <= 1'b0;
      if (i_ramp_done) begin
        ready_q <= 1'b1;  // Charge finished
      end
      if (i_fault) begin
        state_q <= FAULT;  // Locked until reset
        o_fan   <= 1'b1;
        ready_q <= 1'b0;
      end else if (strobe_fall && !i_busy) begin
        case (state_q)
          IDLE: begin
            case (i_cmd)
              CMD_PAUSE: o_bridge_off <= ~i_ramping;
              CMD_PLUS, CMD_MINUS, CMD_BALLAST_P, CMD_BALLAST_N: begin
                o_bridge_load <= accept_leg;
              end
              CMD_START: state_q <= i_ramping ? IDLE : START_ARM;
              CMD_SHUTDOWN: begin
                o_bridge_off <= 1'b1;
                o_abort      <= 1'b1;
                o_fan        <= 1'b0;
                ready_q      <= 1'b0;
              end
              CMD_DISCHARGE: state_q <= i_ramping ? IDLE : DISCH_0;
            endcase
          end
          START_ARM: begin
            if (i_cmd == CMD_PAUSE) begin
              o_start_req  <= 1'b1;
              o_bridge_off <= 1'b1;  // Bridge off while charging
              o_fan        <= 1'b1;
            end
            state_q <= IDLE;
          end
          DISCH_0: state_q <= (i_cmd == CMD_PAUSE) ? DISCH_1 : IDLE;
          DISCH_1: state_q <= (i_cmd == CMD_DISCHARGE) ? DISCH_2 : IDLE;
          DISCH_2: begin
            if (i_cmd == CMD_PAUSE) begin
              ready_q <= 1'b1;  // Unlock complete
            end
            state_q <= IDLE;
          end
          default: state_q <= state_q;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/fault_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module fault_monitor
  import bridge_ctrl_pkg::*;
(
  input  wire    clk,
  input  wire    rstn,
  input  wire  fault_t i_faults,
  output logic   o_fault,
  output logic   o_stop,
  output logic   o_avv,
  output logic   o_avi,
  output logic   o_td,
  output leg_t   o_erbd
);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_fault <= 1'b0;
      o_stop  <= 1'b0;
      o_avv   <= 1'b0;
      o_avi   <= 1'b0;
      o_td    <= 1'b0;
      o_erbd  <= '0;
    end else begin
      o_fault <= o_fault | (|i_faults);  // Any lane locks the controller
      o_stop  <= o_stop | i_faults.stop_k;
      o_avv   <= o_avv | i_faults.err_u;
      o_avi   <= o_avi | i_faults.err_i;
      o_td    <= o_td | i_faults.bt;
      o_erbd  <= o_erbd | i_faults.err_dr;
    end
  end

endmodule

`default_nettype wire

// ==== design/input_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module input_filter #(
  parameter int WIDTH = 8,
  parameter int LANES = 12
) (
  input  wire              clk,
  input  wire              rstn,
  input  wire  [LANES-1:0] i_raw,
  output logic [LANES-1:0] o_clean
);

  logic [LANES-1:0] meta_q;  // First sync stage
  logic [LANES-1:0] sync_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= i_raw;
      sync_q <= meta_q;
    end
  end

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    logic [WIDTH-1:0] hist_q;  // Last WIDTH samples, newest in bit 0

    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        hist_q     <= '0;
        o_clean[i] <= 1'b0;
      end else begin
        hist_q <= {hist_q[WIDTH-2:0], sync_q[i]};
        if (&hist_q) begin
          o_clean[i] <= 1'b1;  // Stable high
        end else if (~|hist_q) begin
          o_clean[i] <= 1'b0;  // Stable low
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/soft_start.sv ====
`timescale 1ns/100ps
`default_nettype none

module soft_start
  import bridge_ctrl_pkg::*;
#(
  parameter int STEP_CYCLES = 49999999
) (
  input  wire  clk,
  input  wire  rstn,
  input  wire  i_start_req,
  input  wire  i_abort,
  input  wire  i_fault,
  output logic o_ramping,
  output logic o_ramp_done,
  output logic o_start,
  output logic o_charge,
  output logic o_ch
);

  localparam int TMR_W = (STEP_CYCLES > 0) ? $clog2(STEP_CYCLES + 1) : 1;

  typedef logic [TMR_W-1:0] step_tmr_t;
  typedef logic [3:0]       step_idx_t;

  step_tmr_t tmr_q;
  step_idx_t idx_q;       // 0 to 14 ramp steps, 15 final wait
  duty_t     duty_q;
  duty_t     pwm_q;       // Free-running PWM counter
  logic      final_step;

  assign final_step = (idx_q == step_idx_t'(RAMP_STEPS));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pwm_q <= '0;
    end else begin
      pwm_q <= pwm_q + duty_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      o_ramping   <= 1'b0;
      o_ramp_done <= 1'b0;
      o_start     <= 1'b0;
      o_charge    <= 1'b0;
      duty_q      <= '0;
      tmr_q       <= '0;
      idx_q       <= '0;
    end else begin
      o_ramp_done <= 1'b0;
      if (i_fault || i_abort) begin
        o_ramping <= 1'b0;
        o_start   <= 1'b0;
        o_charge  <= 1'b0;
        duty_q    <= '0;
      end else if (i_start_req) begin
        o_ramping <= 1'b1;
        o_start   <= 1'b0;
        o_charge  <= 1'b1;
        idx_q     <= '0;
        duty_q    <= RAMP_DUTY[0];
        tmr_q     <= step_tmr_t'(STEP_CYCLES);
      end else if (o_ramping) begin
        if (tmr_q != '0) begin
          tmr_q <= tmr_q - step_tmr_t'(1);
        end else if (final_step) begin
          o_ramping   <= 1'b0;
          o_charge    <= 1'b0;  // Charge switch off, device ready
          duty_q      <= '0;
          o_ramp_done <= 1'b1;
        end else begin
          idx_q <= idx_q + step_idx_t'(1);
          tmr_q <= step_tmr_t'(STEP_CYCLES);
          if (idx_q == step_idx_t'(RAMP_STEPS - 1)) begin
            o_start <= 1'b1;  // Ramp complete, duty held at full
          end else begin
            duty_q <= RAMP_DUTY[idx_q + step_idx_t'(1)];
          end
        end
      end
    end
  end

  assign o_ch = o_charge & ((pwm_q < duty_q) | (&duty_q));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module bridge_ctrl_tb -o bridge_ctrl_tb

out=$(./obj_dir/bridge_ctrl_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF 'TEST RESULT: PASS'; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim/bridge_ctrl_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridge_ctrl_tb
  import bridge_ctrl_pkg::*;
();

  localparam int FILTER_WIDTH = 4;
  localparam int WAITSTATES   = 4;
  localparam int STEP_CYCLES  = 31;
  localparam int RAMP_CYCLES  = 17 * (STEP_CYCLES + 1);
  localparam int STEP15_WAIT  = 14 * (STEP_CYCLES + 1) - 36;  // Lands inside step 15
  localparam int STROBE_HALF  = 12;  // Strobe high and low time in cycles
  localparam int RESET_CYCLES = 4;
  localparam int SETTLE       = 10;  // Idle cycles before the reset check

  localparam logic [3:0] MODE_PLUS  = 4'b1000;  // plus, minus, pause_p, pause_n
  localparam logic [3:0] MODE_MINUS = 4'b0100;
  localparam logic [3:0] MODE_BAL_P = 4'b0010;
  localparam logic [3:0] MODE_BAL_N = 4'b0001;
  localparam logic [3:0] ST_FAN     = 4'b1000;  // fan, start, charge, break
  localparam logic [3:0] ST_START   = 4'b0100;
  localparam logic [3:0] ST_CHARGE  = 4'b0010;
  localparam logic [3:0] ST_BREAK   = 4'b0001;
  localparam logic [3:0] IND_AVV    = 4'b0100;  // stop, avv, avi, td

  localparam fault_t NO_FAULT = 8'h00;
  localparam fault_t ERR_U    = 8'h08;  // Overvoltage lane only

  typedef struct packed {
    leg_t       top;
    leg_t       bot;
    logic [3:0] mode;
    logic [3:0] status;
    logic [3:0] ind;
    leg_t       erbd;
    logic       ch_full;  // Charge switch held on by full duty
  } expect_t;

  typedef struct packed {
    cmd_code_t code;
    fault_t    faults;
    int        glitch;    // Fault pulse length, 0 holds the mask
    int        wait_len;
    expect_t   exp;
  } entry_t;

  logic      clk;
  logic      rstn;
  logic      i_strobe;
  cmd_code_t i_cmd;
  leg_t      i_err_dr_n;
  logic      i_err_u_n;
  logic      i_err_i_n;
  logic      i_bt_n;
  logic      i_stop_k_n;
  leg_t      o_top;
  leg_t      o_bot;
  logic      o_plus;
  logic      o_minus;
  logic      o_pause_p;
  logic      o_pause_n;
  logic      o_fan;
  logic      o_start;
  logic      o_charge;
  logic      o_ch;
  logic      o_break;
  logic      o_stop;
  logic      o_avv;
  logic      o_avi;
  logic      o_td;
  leg_t      o_erbd;

  entry_t table_q[$];
  integer seed;
  int     cycle_cnt   = 0;
  int     cycle_limit = 0;
  int     entry_idx   = -1;

  bridge_ctrl_top #(
    .FILTER_WIDTH(FILTER_WIDTH),
    .WAITSTATES(WAITSTATES),
    .STEP_CYCLES(STEP_CYCLES)
  ) dut_i (
    .clk(clk), .rstn(rstn), .i_strobe(i_strobe), .i_cmd(i_cmd),
    .i_err_dr_n(i_err_dr_n), .i_err_u_n(i_err_u_n), .i_err_i_n(i_err_i_n),
    .i_bt_n(i_bt_n), .i_stop_k_n(i_stop_k_n),
    .o_top(o_top), .o_bot(o_bot), .o_plus(o_plus), .o_minus(o_minus),
    .o_pause_p(o_pause_p), .o_pause_n(o_pause_n), .o_fan(o_fan), .o_start(o_start),
    .o_charge(o_charge), .o_ch(o_ch), .o_break(o_break), .o_stop(o_stop),
    .o_avv(o_avv), .o_avi(o_avi), .o_td(o_td), .o_erbd(o_erbd)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("The run did not finish within %0d clock cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped by the cycle limit");
    end
  end

  // Advance n rising edges, then step past the edge
  task automatic next_cycles(input int n);
    if (n > 0) begin
      repeat (n) @(posedge clk);
      #1;
    end
  endtask

  task automatic drive_faults(input fault_t f);
    i_err_dr_n = ~f.err_dr;  // Pins are active low
    i_err_u_n  = ~f.err_u;
    i_err_i_n  = ~f.err_i;
    i_bt_n     = ~f.bt;
    i_stop_k_n = ~f.stop_k;
  endtask

  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
    if (actual !== expected) begin
      $display("error %s in entry %0d: expected 0x%0h, got 0x%0h",
               name, entry_idx, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic compare_outputs(input expect_t e);
    check_value("o_top", 8'(o_top), 8'(e.top));
    check_value("o_bot", 8'(o_bot), 8'(e.bot));
    check_value("o_plus", 8'(o_plus), 8'(e.mode[3]));
    check_value("o_minus", 8'(o_minus), 8'(e.mode[2]));
    check_value("o_pause_p", 8'(o_pause_p), 8'(e.mode[1]));
    check_value("o_pause_n", 8'(o_pause_n), 8'(e.mode[0]));
    check_value("o_fan", 8'(o_fan), 8'(e.status[3]));
    check_value("o_start", 8'(o_start), 8'(e.status[2]));
    check_value("o_charge", 8'(o_charge), 8'(e.status[1]));
    check_value("o_break", 8'(o_break), 8'(e.status[0]));
    check_value("o_stop", 8'(o_stop), 8'(e.ind[3]));
    check_value("o_avv", 8'(o_avv), 8'(e.ind[2]));
    check_value("o_avi", 8'(o_avi), 8'(e.ind[1]));
    check_value("o_td", 8'(o_td), 8'(e.ind[0]));
    check_value("o_erbd", 8'(o_erbd), 8'(e.erbd));
    if (!e.status[1]) begin
      check_value("o_ch", 8'(o_ch), 8'h00);  // PWM gated by charge enable
    end else if (e.ch_full) begin
      check_value("o_ch", 8'(o_ch), 8'h01);  // Duty all ones keeps the switch on
    end
  endtask

  task automatic apply_entry(input entry_t e);
    int gap;
    gap = $random(seed) & 7;
    next_cycles(gap);
    i_cmd = e.code;
    drive_faults(e.faults);
    i_strobe = 1'b1;
    if (e.glitch > 0) begin
      next_cycles(e.glitch);
      drive_faults(NO_FAULT);  // Pulse ends early
      next_cycles(STROBE_HALF - e.glitch);
    end else begin
      next_cycles(STROBE_HALF);
    end
    i_strobe = 1'b0;  // Falling edge carries the command
    next_cycles(STROBE_HALF);
    next_cycles(e.wait_len);
    compare_outputs(e.exp);
  endtask

  function automatic expect_t expect_out(input leg_t top, input leg_t bot,
                                         input logic [3:0] mode, input logic [3:0] status,
                                         input logic [3:0] ind);
    expect_t e;
    e.top     = top;
    e.bot     = bot;
    e.mode    = mode;
    e.status  = status;
    e.ind     = ind;
    e.erbd    = '0;  // No driver faults injected
    e.ch_full = 1'b0;
    return e;
  endfunction

  function automatic void add_entry(input cmd_code_t code, input fault_t faults,
                                    input int glitch, input int wait_len, input expect_t exp);
    entry_t e;
    e.code     = code;
    e.faults   = faults;
    e.glitch   = glitch;
    e.wait_len = wait_len;
    e.exp      = exp;
    table_q.push_back(e);
  endfunction

  function automatic void build_table();
    expect_t idle;
    expect_t plus_only;
    expect_t plus_on;
    expect_t charging;
    expect_t full_duty;
    expect_t locked;
    idle      = expect_out(4'b0000, 4'b0000, 4'b0000, 4'b0000, 4'b0000);
    plus_only = expect_out(4'b0001, 4'b0010, MODE_PLUS, 4'b0000, 4'b0000);
    plus_on   = expect_out(4'b0001, 4'b0010, MODE_PLUS, ST_FAN | ST_START, 4'b0000);
    charging  = expect_out(4'b0000, 4'b0000, 4'b0000, ST_FAN | ST_CHARGE, 4'b0000);
    full_duty = charging;
    full_duty.ch_full = 1'b1;  // Step 15 runs at duty all ones
    locked    = expect_out(4'b0000, 4'b0000, 4'b0000, ST_FAN | ST_BREAK, IND_AVV);
    add_entry(CMD_PLUS, NO_FAULT, 0, 20, idle);  // Not ready yet
    add_entry(CMD_DISCHARGE, NO_FAULT, 0, 20, idle);
    add_entry(CMD_PAUSE, NO_FAULT, 0, 20, idle);
    add_entry(CMD_DISCHARGE, NO_FAULT, 0, 20, idle);
    add_entry(CMD_PAUSE, NO_FAULT, 0, 20, idle);  // Unlock done
    add_entry(CMD_PLUS, NO_FAULT, 0, 20, expect_out(4'b0001, 4'b0010, MODE_PLUS, 0, 0));
    add_entry(CMD_MINUS, NO_FAULT, 0, 20, expect_out(4'b0010, 4'b0001, MODE_MINUS, 0, 0));
    add_entry(CMD_BALLAST_P, NO_FAULT, 0, 20, expect_out(4'b0100, 4'b1000, MODE_BAL_P, 0, 0));
    add_entry(CMD_BALLAST_N, NO_FAULT, 0, 20, expect_out(4'b1000, 4'b0100, MODE_BAL_N, 0, 0));
    add_entry(CMD_PAUSE, NO_FAULT, 0, 20, idle);
    add_entry(CMD_PLUS, NO_FAULT, 0, 20, plus_only);
    add_entry(CMD_START, NO_FAULT, 0, 20, plus_only);
    add_entry(CMD_PAUSE, NO_FAULT, 0, 20, charging);  // Fan on before shutdown
    add_entry(CMD_SHUTDOWN, NO_FAULT, 0, 20, idle);
    add_entry(CMD_PLUS, NO_FAULT, 0, 20, idle);  // Dropped after shutdown
    add_entry(CMD_START, NO_FAULT, 0, 20, idle);
    add_entry(CMD_PAUSE, NO_FAULT, 0, 20, charging);
    // Pause is ignored while the ramp runs
    add_entry(CMD_PAUSE, NO_FAULT, 0, STEP15_WAIT, full_duty);
    add_entry(CMD_PAUSE, NO_FAULT, 0, RAMP_CYCLES, expect_out(0, 0, 0, ST_FAN | ST_START, 0));
    add_entry(CMD_PLUS, NO_FAULT, 0, 20, plus_on);
    add_entry(CMD_PLUS, ERR_U, FILTER_WIDTH - 2, 20, plus_on);  // Short glitch
    add_entry(CMD_SHUTDOWN, NO_FAULT, 0, 20, idle);  // Fan low again
    add_entry(CMD_DISCHARGE, NO_FAULT, 0, 20, idle);
    add_entry(CMD_PAUSE, NO_FAULT, 0, 20, idle);
    add_entry(CMD_DISCHARGE, NO_FAULT, 0, 20, idle);
    add_entry(CMD_PAUSE, NO_FAULT, 0, 20, idle);
    add_entry(CMD_PLUS, NO_FAULT, 0, 20, plus_only);
    add_entry(CMD_PAUSE, ERR_U, 0, 20, locked);
    add_entry(CMD_PLUS, ERR_U, 0, 20, locked);
    add_entry(CMD_START, ERR_U, 0, 20, locked);
    add_entry(CMD_PAUSE, ERR_U, 0, 20, locked);
  endfunction

  initial begin
    int sum;
    seed     = 32'he09a_50ce;
    rstn     = 1'b0;
    i_strobe = 1'b0;
    i_cmd    = CMD_PAUSE;
    drive_faults(NO_FAULT);
    build_table();
    sum = RESET_CYCLES + SETTLE;
    foreach (table_q[i]) begin
      sum += 2 * STROBE_HALF + 7 + table_q[i].wait_len;
    end
    cycle_limit = 3 * (sum + RAMP_CYCLES) / 2;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn = 1'b1;
    next_cycles(SETTLE);
    compare_outputs('0);  // Everything low after reset
    foreach (table_q[i]) begin
      entry_idx = i;
      apply_entry(table_q[i]);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
design/bridge_ctrl_pkg.sv
design/input_filter.sv
design/cmd_decoder.sv
design/bridge_driver.sv
design/soft_start.sv
design/fault_monitor.sv
design/bridge_ctrl_top.sv
sim/bridge_ctrl_tb.sv
